//--- build.f
+incdir+include
rtl/zclk_pkg.sv
rtl/clk_phase_gen.sv
rtl/turbo_switch.sv
rtl/wait_gen.sv
rtl/zclock.sv
rtl/z80_clk_top.sv
test/z80_clk_assertions.sv
test/tb_z80_clk.sv

//--- test/z80_clk_vectors.txt
# name req rfsh kind len window exp_turbo exp_zpos
# kind is none, cpu, dos or io; len is the cpu stall length in cycles
# speed after reset, then each speed after a refresh
reset_35       0 0 none 0 32 0 4
rate_7         1 1 none 0 32 1 8
rate_14        2 1 none 0 32 2 16
rate_14_code3  3 1 none 0 32 3 16
rate_35        0 1 none 0 64 0 8
# request without refresh keeps the old speed
hold_req_14    2 0 none 0 32 0 4
apply_req_14   2 1 none 0 32 2 16
hold_req_7     1 0 none 0 32 2 16
apply_req_7    1 1 none 0 32 1 8
hold_req_35    0 0 none 0 64 1 16
back_to_14     2 1 none 0 32 2 16
# stalls at 14 MHz, clock resumes two cycles after the stall
cpu_stall_14   2 0 cpu  6 32 2 13
cpu_long_14    2 0 cpu 20 32 2 6
dos_14         2 0 dos  0 32 2 14
io_14          2 0 io   0 32 2 12
io_14_code3    3 1 io   0 32 3 12
# stalls at 7 MHz, io access needs no fallback here
to_7           1 1 none 0 32 1 8
io_7           1 0 io   0 32 1 8
dos_7          1 0 dos  0 32 1 7
cpu_stall_7    1 0 cpu  8 32 1 6
# stalls at 3.5 MHz
to_35          0 1 none 0 64 0 8
io_35          0 0 io   0 64 0 8
dos_35         0 0 dos  0 64 0 7
cpu_stall_35   0 0 cpu  4 64 0 7

//--- test/tb_z80_clk.sv
/*
  Z80 clocking testbench
  reads speed and stall tests from the vector file, counts zpos
  strobes over a window, checks the active speed and stall gaps
*/
`include "zclk_settings.svh"

module tb_z80_clk;

  import zclk_pkg::*;

  localparam int RESET_CYCLES  = 10;
  localparam int SETTLE_CYCLES = 16;
  localparam int VECTOR_SLACK  = 32;

  logic   clk = 1'b0;
  logic   rst_n;
  logic   rfsh_n;
  logic   iorq_s;
  logic   external_port;
  logic   cpu_stall;
  logic   ide_stall;
  logic   dos_on;
  logic   vdos_off;
  turbo_t turbo_req;
  logic   zclk_out;
  logic   zpos;
  logic   zneg;
  logic   c0;
  logic   c1;
  logic   c2;
  logic   c3;
  turbo_t turbo;

  // one entry per vector line
  string  vec_name[$];
  turbo_t vec_req[$];
  int     vec_rfsh[$];
  string  vec_kind[$];
  int     vec_len[$];
  int     vec_window[$];
  turbo_t vec_turbo[$];
  int     vec_count[$];

  int cycle_cnt = 0;
  int cycle_limit = 0;

  // test that is running now
  string cur_test = "reset";
  // zclk_out level that the last strobe leads to, low from reset
  logic  zclk_exp = 1'b0;

  z80_clk_top u_z80_clk_top
  (
    .clk (clk), .rst_n (rst_n), .rfsh_n (rfsh_n), .iorq_s (iorq_s),
    .external_port (external_port), .cpu_stall (cpu_stall), .ide_stall (ide_stall),
    .dos_on (dos_on), .vdos_off (vdos_off), .turbo_req (turbo_req),
    .zclk_out (zclk_out), .zpos (zpos), .zneg (zneg),
    .c0 (c0), .c1 (c1), .c2 (c2), .c3 (c3), .turbo (turbo)
  );

  // 28 MHz master clock
  always #2 clk = ~clk;

  task automatic stop_with_failure();
    $display("Some tests failed");
    $fatal(1, "run stopped at the first error");
  endtask

  function automatic int assertion_failures();
    return u_z80_clk_top.u_zclock.u_strobe_chk.fail_cnt +
           u_z80_clk_top.u_wait.u_count_chk.fail_cnt;
  endfunction

  // watchdog and bound assertion monitor
  always @(posedge clk)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt > cycle_limit)
    begin
      $display("timeout: tests still running after %0d cycles", cycle_cnt);
      stop_with_failure();
    end
    if (assertion_failures() != 0)
    begin
      $display("a bound assertion on the strobes or wait counter failed");
      stop_with_failure();
    end
  end

  // strobe-free cycles after the trigger
  // io only falls back at 14 MHz
  function automatic int stall_length(input string kind, input int len, input turbo_t spd);
    if (kind == "cpu")
      return len;
    if (kind == "dos")
      return 5;
    if (kind == "io")
      return spd[1] ? 9 : 0;
    return 0;
  endfunction

  task automatic check_turbo(input string name, input turbo_t exp_val, input turbo_t act_val);
    if (act_val !== exp_val)
    begin
      $display("Fail %s: turbo expected %0d, actual %0d", name, exp_val, act_val);
      stop_with_failure();
    end
  endtask

  task automatic check_count(input string name, input int exp_val, input int act_val);
    if (act_val != exp_val)
    begin
      $display("Fail %s: zpos count expected %0d, actual %0d", name, exp_val, act_val);
      stop_with_failure();
    end
  endtask

  task automatic check_quiet(input string name, input int step, input logic zp, input logic zn);
    if (zp !== 1'b0 || zn !== 1'b0)
    begin
      $display("Fail %s: expected no strobe in stall cycle %0d, actual zpos %b zneg %b",
               name, step, zp, zn);
      stop_with_failure();
    end
  endtask

  task automatic check_phase(input string name, input logic [3:0] exp_val,
                             input logic [3:0] act_val);
    if (act_val !== exp_val)
    begin
      $display("Fail %s: phase strobes c3..c0 expected %b, actual %b",
               name, exp_val, act_val);
      stop_with_failure();
    end
  endtask

  task automatic check_level(input string name, input logic exp_val, input logic act_val);
    if (act_val !== exp_val)
    begin
      $display("Fail %s: zclk_out expected %b, actual %b", name, exp_val, act_val);
      stop_with_failure();
    end
  endtask

  // phase strobes c0 to c3 in turn with c0 in the first cycle after reset
  // strobes are stable at the falling edge
  always @(negedge clk)
  begin
    if (cycle_cnt >= RESET_CYCLES)
      check_phase(cur_test, 4'b0001 << ((cycle_cnt - RESET_CYCLES) % 4),
                  {c3, c2, c1, c0});
    // zpos takes zclk_out low and zneg takes it high
    if (zpos === 1'b1)
      zclk_exp = 1'b0;
    else if (zneg === 1'b1)
      zclk_exp = 1'b1;
  end

  // zclk_out only moves on the falling edge
  always @(posedge clk)
  begin
    if (rst_n === 1'b1)
      check_level(cur_test, zclk_exp, zclk_out);
  end

  task automatic read_vectors();
    int    fd;
    int    got;
    string line;
    string name;
    string kind;
    int    req;
    int    rfsh;
    int    len;
    int    window;
    int    exp_turbo;
    int    exp_count;
    begin
      fd = $fopen("test/z80_clk_vectors.txt", "r");
      if (fd == 0)
      begin
        $display("cannot open the vector file test/z80_clk_vectors.txt");
        stop_with_failure();
      end
      while (!$feof(fd))
      begin
        got = $fgets(line, fd);
        // comment lines start with a hash
        if (got > 0 && line.getc(0) != "#")
        begin
          got = $sscanf(line, "%s %d %d %s %d %d %d %d", name, req, rfsh, kind, len,
                        window, exp_turbo, exp_count);
          if (got == 8)
          begin
            vec_name.push_back(name);
            vec_req.push_back(req);
            vec_rfsh.push_back(rfsh);
            vec_kind.push_back(kind);
            vec_len.push_back(len);
            vec_window.push_back(window);
            vec_turbo.push_back(exp_turbo);
            vec_count.push_back(exp_count);
          end
        end
      end
      $fclose(fd);
      if (vec_name.size() == 0)
      begin
        $display("no test vectors found in the vector file");
        stop_with_failure();
      end
    end
  endtask

  // trigger on the first window cycle, pulses end one cycle later
  task automatic drive_stall(input string kind, input int len, input int step);
    if (step == 0)
    begin
      cpu_stall     = (kind == "cpu");
      dos_on        = (kind == "dos");
      iorq_s        = (kind == "io");
      external_port = (kind == "io");
    end
    if (step == 1)
    begin
      dos_on        = 1'b0;
      iorq_s        = 1'b0;
      external_port = 1'b0;
    end
    if (kind == "cpu" && step == len)
      cpu_stall = 1'b0;
  endtask

  task automatic run_vector(input int k);
    string name;
    int    quiet;
    int    zpos_cnt;
    int    i;
    begin
      name     = vec_name[k];
      cur_test = name;
      quiet    = stall_length(vec_kind[k], vec_len[k], vec_turbo[k]);
      zpos_cnt = 0;
      turbo_req = vec_req[k];
      // refresh low for two cycles, speed loads when it rises
      if (vec_rfsh[k] != 0)
      begin
        rfsh_n = 1'b0;
        repeat (2) @(negedge clk);
        rfsh_n = 1'b1;
      end
      repeat (SETTLE_CYCLES) @(negedge clk);
      check_turbo(name, vec_turbo[k], turbo);
      // window opens on a zpos pulse
      while (zpos !== 1'b1)
        @(negedge clk);
      for (i = 0; i < vec_window[k]; i++)
      begin
        if (i > 0)
          @(negedge clk);
        if (zpos === 1'b1)
          zpos_cnt++;
        if (i >= 1 && i <= quiet)
          check_quiet(name, i, zpos, zneg);
        drive_stall(vec_kind[k], vec_len[k], i);
      end
      check_count(name, vec_count[k], zpos_cnt);
    end
  endtask

  initial
  begin
    rst_n         = 1'b0;
    rfsh_n        = 1'b1;
    iorq_s        = 1'b0;
    external_port = 1'b0;
    cpu_stall     = 1'b0;
    ide_stall     = 1'b0;
    dos_on        = 1'b0;
    vdos_off      = 1'b0;
    turbo_req     = `ZCLK_TURBO_RESET;
    read_vectors();
    // reset, then per vector its window, stall and fixed overhead
    cycle_limit = RESET_CYCLES;
    foreach (vec_name[k])
      cycle_limit += vec_window[k] + VECTOR_SLACK +
                     stall_length(vec_kind[k], vec_len[k], vec_turbo[k]);
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    foreach (vec_name[k])
      run_vector(k);
    if (assertion_failures() != 0)
    begin
      $display("bound assertions reported %0d failures", assertion_failures());
      stop_with_failure();
    end
    else
    begin
      $display("All tests passed");
      $finish;
    end
  end

endmodule

//--- test/z80_clk_assertions.sv
/*
  Z80 clock assertions
  strobe rules of the clock generator and wait counter sanity,
  bound into zclock and into wait_gen
*/
`include "zclk_settings.svh"

module z80_clk_assertions
(
  input logic                 clk,
  input logic                 rst_n,
  input logic                 zpos,
  input logic                 zneg,
  input logic                 stall,
  input zclk_pkg::stall_cnt_t stall_cnt
);

  import zclk_pkg::*;

  localparam stall_cnt_t CNT_DONE = `ZCLK_STALL_DONE;

  // failure count, summed by the testbench
  int fail_cnt = 0;

  // zneg strobes since the last zpos, saturates at 3
  logic [1:0] zneg_seen;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      zneg_seen <= 2'd0;
    else if (zpos)
      zneg_seen <= 2'd0;
    else if (zneg && zneg_seen != 2'd3)
      zneg_seen <= zneg_seen + 2'd1;
  end

  // rising and falling strobe never together
  assert property (@(posedge clk) disable iff (!rst_n) !(zpos && zneg))
  else
  begin
    fail_cnt++;
    $error("zpos and zneg high in the same cycle");
  end

  // a stall cycle suppresses the next strobe
  assert property (@(posedge clk) disable iff (!rst_n) stall |=> !zpos && !zneg)
  else
  begin
    fail_cnt++;
    $error("strobe in the cycle after a stall");
  end

  // exactly one zneg between two zpos
  assert property (@(posedge clk) disable iff (!rst_n) zpos |-> zneg_seen == 2'd1)
  else
  begin
    fail_cnt++;
    $error("zpos without exactly one zneg before it");
  end

  assert property (@(posedge clk) disable iff (!rst_n) zneg |-> zneg_seen == 2'd0)
  else
  begin
    fail_cnt++;
    $error("two zneg strobes without a zpos between");
  end

  // idle counter rests exactly at the done value, never beyond it
  assert property (@(posedge clk) disable iff (!rst_n)
    !stall |-> stall_cnt == CNT_DONE)
  else
  begin
    fail_cnt++;
    $error("wait counter not at its end value outside a stall");
  end

endmodule

bind zclock z80_clk_assertions u_strobe_chk
(
  .clk (clk), .rst_n (rst_n), .zpos (zpos), .zneg (zneg),
  .stall (stall), .stall_cnt (`ZCLK_STALL_DONE)
);

bind wait_gen z80_clk_assertions u_count_chk
(
  .clk (clk), .rst_n (rst_n), .zpos (1'b0), .zneg (1'b0),
  .stall (stall), .stall_cnt (stall_cnt)
);

//--- rtl/z80_clk_top.sv
/*
  Z80 clocking subsystem
  phase strobes, speed switch at refresh end, wait states
  and the Z80 clock with its zpos and zneg strobes
*/
module z80_clk_top
(
  input  logic             clk,
  input  logic             rst_n,
  input  logic             rfsh_n,
  input  logic             iorq_s,
  input  logic             external_port,
  input  logic             cpu_stall,
  input  logic             ide_stall,
  input  logic             dos_on,
  input  logic             vdos_off,
  input  zclk_pkg::turbo_t turbo_req,
  output logic             zclk_out,
  output logic             zpos,
  output logic             zneg,
  output logic             c0,
  output logic             c1,
  output logic             c2,
  output logic             c3,
  output zclk_pkg::turbo_t turbo
);

  // merged stall level from the wait generator
  logic stall;

  clk_phase_gen u_phase
  (
    .clk   (clk),
    .rst_n (rst_n),
    .c0    (c0),
    .c1    (c1),
    .c2    (c2),
    .c3    (c3)
  );

  // active speed, shared by the wait and clock blocks
  turbo_switch u_turbo
  (
    .clk       (clk),
    .rst_n     (rst_n),
    .rfsh_n    (rfsh_n),
    .turbo_req (turbo_req),
    .turbo     (turbo)
  );

  wait_gen u_wait
  (
    .clk           (clk),
    .rst_n         (rst_n),
    .cpu_stall     (cpu_stall),
    .ide_stall     (ide_stall),
    .dos_on        (dos_on),
    .vdos_off      (vdos_off),
    .iorq_s        (iorq_s),
    .external_port (external_port),
    .turbo         (turbo),
    .stall         (stall)
  );

  zclock u_zclock
  (
    .clk      (clk),
    .rst_n    (rst_n),
    .c0       (c0),
    .c2       (c2),
    .stall    (stall),
    .turbo    (turbo),
    .zclk_out (zclk_out),
    .zpos     (zpos),
    .zneg     (zneg)
  );

endmodule

//--- rtl/zclock.sv
/*
  Z80 clock generator
  picks the pre-strobes of the active speed, qualifies them with
  stall and the clock level, registers zpos and zneg and builds
  zclk_out from them on the falling edge of clk
*/
module zclock
(
  input  logic             clk,
  input  logic             rst_n,
  input  logic             c0,
  input  logic             c2,
  input  logic             stall,
  input  zclk_pkg::turbo_t turbo,
  output logic             zclk_out,
  output logic             zpos,
  output logic             zneg
);

  // 14 MHz source, frozen during a stall
  logic clk14_src;
  // halves the c2 rate for 3.5 MHz
  logic c2_cnt;

  logic pre_zpos_140;
  logic pre_zneg_140;
  logic pre_zpos_70;
  logic pre_zneg_70;
  logic pre_zpos_35;
  logic pre_zneg_35;
  logic pre_zpos;
  logic pre_zneg;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      clk14_src <= 1'b0;
    else if (!stall)
      clk14_src <= ~clk14_src;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      c2_cnt <= 1'b0;
    else if (c2)
      c2_cnt <= ~c2_cnt;
  end

  // 14 MHz, every other cycle
  assign pre_zpos_140 = clk14_src;
  assign pre_zneg_140 = ~clk14_src;

  // 7 MHz, rise on c2 and fall on c0
  assign pre_zpos_70 = c2;
  assign pre_zneg_70 = c0;

  // 3.5 MHz, c2 takes turns as rise and fall
  assign pre_zpos_35 = c2_cnt && c2;
  assign pre_zneg_35 = !c2_cnt && c2;

  // speed select, bit 1 first so 2 and 3 both give 14 MHz
  assign pre_zpos = turbo[1] ? pre_zpos_140 : (turbo[0] ? pre_zpos_70 : pre_zpos_35);
  assign pre_zneg = turbo[1] ? pre_zneg_140 : (turbo[0] ? pre_zneg_70 : pre_zneg_35);

  // rising strobe only while the clock is high, falling only while low
  // keeps them alternating whatever the phase after a speed change
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      zpos <= 1'b0;
      zneg <= 1'b0;
    end
    else
    begin
      zpos <= !stall && pre_zpos && zclk_out;
      zneg <= !stall && pre_zneg && !zclk_out;
    end
  end

  // output is inverted outside the chip
  // so zpos pulls it low and zneg pulls it high
  // half a cycle early on purpose, gives the pad some lead
  always_ff @(negedge clk or negedge rst_n)
  begin
    if (!rst_n)
      zclk_out <= 1'b0;
    else if (zpos)
      zclk_out <= 1'b0;
    else if (zneg)
      zclk_out <= 1'b1;
  end

endmodule

//--- rtl/wait_gen.sv
/*
  Wait state generator
  counts short fixed stalls on dos entry or exit and on external
  port access at 14 MHz, and merges them with the held stall levels
*/
`include "zclk_settings.svh"

module wait_gen
(
  input  logic             clk,
  input  logic             rst_n,
  input  logic             cpu_stall,
  input  logic             ide_stall,
  input  logic             dos_on,
  input  logic             vdos_off,
  input  logic             iorq_s,
  input  logic             external_port,
  input  zclk_pkg::turbo_t turbo,
  output logic             stall
);

  import zclk_pkg::*;

  stall_cnt_t stall_cnt;

  logic dos_stall;
  logic io_stall;
  logic stall_start;
  logic cnt_done;

  // dos paging change, either direction
  assign dos_stall = dos_on || vdos_off;

  // external io only needs the fallback at 14 MHz
  // 7 and 3.5 MHz are slow enough for the bus
  assign io_stall = iorq_s && external_port && turbo[1];

  assign stall_start = dos_stall || io_stall;

  // bit 3 marks the end of the count
  assign cnt_done = stall_cnt[3];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      stall_cnt <= `ZCLK_STALL_DONE;
    else if (stall_start)
    begin
      // dos load wins on a tie
      if (dos_stall)
        stall_cnt <= `ZCLK_DOS_STALL_LOAD;
      else
        stall_cnt <= `ZCLK_IO_STALL_LOAD;
    end
    else if (!cnt_done)
      stall_cnt <= stall_cnt + 4'd1;
  end

  // trigger stalls in its own cycle
  // then for as long as the counter runs
  assign stall = cpu_stall || ide_stall || stall_start || !cnt_done;

endmodule

//--- rtl/turbo_switch.sv
/*
  CPU speed switch
  holds the active Z80 speed and takes the requested one
  only when a refresh cycle ends, so no bus cycle sees a change
*/
`include "zclk_settings.svh"

module turbo_switch
(
  input  logic             clk,
  input  logic             rst_n,
  input  logic             rfsh_n,
  input  zclk_pkg::turbo_t turbo_req,
  output zclk_pkg::turbo_t turbo
);

  import zclk_pkg::*;

  rfsh_state_t state;
  rfsh_state_t state_next;

  // high in the cycle rfsh_n is back high after a low stretch
  logic rfsh_end;

  always_comb
  begin
    state_next = state;
    rfsh_end   = 1'b0;
    case (state)
      idle:
      begin
        // refresh starts
        if (!rfsh_n)
          state_next = in_rfsh;
      end
      in_rfsh:
      begin
        if (rfsh_n)
        begin
          state_next = idle;
          rfsh_end   = 1'b1;
        end
      end
      default:
        state_next = idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state <= idle;
      turbo <= `ZCLK_TURBO_RESET;
    end
    else
    begin
      state <= state_next;
      // new speed visible one cycle after the rising rfsh_n
      if (rfsh_end)
        turbo <= turbo_req;
    end
  end

endmodule

//--- rtl/clk_phase_gen.sv
/*
  Phase strobe generator
  splits the 7 MHz period into four 28 MHz cycles
  and drives one registered one-hot strobe per cycle, c0 first
*/
module clk_phase_gen
(
  input  logic clk,
  input  logic rst_n,
  output logic c0,
  output logic c1,
  output logic c2,
  output logic c3
);

  import zclk_pkg::*;

  // index of the phase that the strobes show next
  phase_t phase;

  // strobes decoded from phase one cycle ahead
  // so every strobe comes straight from a flop
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      // c0 is up in the first cycle, c1 follows
      phase <= 2'd1;
      c0    <= 1'b1;
      c1    <= 1'b0;
      c2    <= 1'b0;
      c3    <= 1'b0;
    end
    else
    begin
      phase <= phase + 2'd1;
      c0    <= (phase == 2'd0);
      c1    <= (phase == 2'd1);
      c2    <= (phase == 2'd2);
      c3    <= (phase == 2'd3);
    end
  end

endmodule

//--- rtl/zclk_pkg.sv
/*
  Z80 clock package
  shared vector types and the refresh detector states
*/
package zclk_pkg;

  // cpu speed code
  // 2'b00 3.5 MHz
  // 2'b01 7 MHz
  // 2'b1x 14 MHz
  typedef logic [1:0] turbo_t;

  // wait counter
  // bit 3 high once the count is finished
  typedef logic [3:0] stall_cnt_t;

  // index of the 28 MHz cycle inside one 7 MHz period
  typedef logic [1:0] phase_t;

  // refresh end detection
  // idle until rfsh_n goes low, in_rfsh until it returns high
  typedef enum logic
  {
    idle,
    in_rfsh
  } rfsh_state_t;

endpackage

//--- include/zclk_settings.svh
/*
  Z80 clock settings
  preload values of the wait counter and the CPU speed after reset
*/
`ifndef ZCLK_SETTINGS_SVH
`define ZCLK_SETTINGS_SVH

// wait counter runs from the preload up to 8
// bit 3 set means the stall is over

// dos entry or vdos exit
// 4 counting cycles after the trigger, one 7 MHz tact
`define ZCLK_DOS_STALL_LOAD 4'd4

// external port access at 14 MHz
// 8 counting cycles after the trigger, one 3.5 MHz tact
`define ZCLK_IO_STALL_LOAD 4'd0

// speed code after reset
// 0 is 3.5 MHz, 1 is 7 MHz, 2 or 3 is 14 MHz
`define ZCLK_TURBO_RESET 2'd0

// counter value with the stall finished
// loaded by reset so that no stall is pending
`define ZCLK_STALL_DONE 4'd8

`endif
